// ==== common/n64v_pkg.sv ====
// shared widths, slot codes and bus structs for the n64 video input stage

package n64v_pkg;

  // =========================================================================
  // widths
  // =========================================================================

  localparam int color_w   = 7;   // one colour word on the console bus
  localparam int h_pix_w   = 12;  // stats field for pixels per line
  localparam int v_lines_w = 10;  // stats field for lines per frame

  // data slot codes, value of data_cnt *before* the sampling edge
  localparam logic [1:0] slot_sync  = 2'd0;  // ndsync low, sync nibble
  localparam logic [1:0] slot_red   = 2'd1;
  localparam logic [1:0] slot_green = 2'd2;
  localparam logic [1:0] slot_blue  = 2'd3;  // pixel complete here

  // =========================================================================
  // structs
  // =========================================================================

  // sync nibble, all active low, same bit order as d[3:0]
  typedef struct packed {
    logic nvsync;  // d[3]
    logic nclamp;  // d[2]
    logic nhsync;  // d[1]
    logic ncsync;  // d[0]
  } sync_t;

  // video info vector
  typedef struct packed {
    logic [1:0] data_cnt;  // slot within current group
    logic       n64_480i;  // 1 = 480i/576i, 0 = 240p/288p
    logic       vmode;     // 1 = pal, 0 = ntsc
  } vinfo_t;

  // one demultiplexed pixel with the sync bits of its group
  typedef struct packed {
    sync_t              sync;
    logic [color_w-1:0] r;
    logic [color_w-1:0] g;
    logic [color_w-1:0] b;
  } pixel_t;

  // per frame statistics, consumed by the osd later on
  typedef struct packed {
    logic [h_pix_w-1:0]   h_pix;    // pixels in last full line
    logic [v_lines_w-1:0] v_lines;  // lines in last frame
  } line_stats_t;

endpackage

// ==== vinfo/n64v_vinfo_ext.sv ====
// video info extraction: data slot counter, 240p/480i and pal/ntsc detection
`timescale 1ns/100ps

module n64v_vinfo_ext (
  input  logic             nclk,
  input  logic             rst_n,
  input  logic             ndsync,
  input  n64v_pkg::sync_t  sync_pre,  // nibble of the group before
  input  n64v_pkg::sync_t  sync_cur,  // nibble of the current group
  output n64v_pkg::vinfo_t vinfo
);

  import n64v_pkg::*;

  logic [1:0] data_cnt;
  logic       frame_id;   // 0 = even frame, 1 = odd frame
  logic       n64_480i;
  logic [1:0] line_cnt;   // pal ends with bit 1 at 0, ntsc with bit 1 at 1
  logic       vmode;

  logic vs_rise, vs_fall;
  logic hs_rise, hs_fall;

  // sync edges between two consecutive groups
  assign vs_rise = !sync_pre.nvsync &  sync_cur.nvsync;
  assign vs_fall =  sync_pre.nvsync & !sync_cur.nvsync;
  assign hs_rise = !sync_pre.nhsync &  sync_cur.nhsync;
  assign hs_fall =  sync_pre.nhsync & !sync_cur.nhsync;

  // =========================================================================
  // data slot counter, sequences the demux
  // =========================================================================

  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n)
      data_cnt <= 2'b00;
    else if (!ndsync)
      data_cnt <= slot_red;          // next edge samples red
    else
      data_cnt <= data_cnt + 2'd1;   // wraps 3 -> 0
  end

  // =========================================================================
  // 240p/288p against 480i/576i
  // =========================================================================

  // vsync falling together with hsync marks an odd field,
  // progressive output keeps the same field parity every frame
  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      frame_id <= 1'b0;
      n64_480i <= 1'b1;  // assume interlaced until proven otherwise
    end else if (!ndsync && vs_fall) begin
      n64_480i <= frame_id ^ hs_fall;  // parity toggled -> interlaced
      frame_id <= hs_fall;
    end
  end

  // =========================================================================
  // pal/ntsc from the vsync line count
  // =========================================================================

  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      line_cnt <= 2'b00;
      vmode    <= 1'b0;
    end else if (!ndsync) begin
      if (vs_rise) begin
        vmode    <= ~line_cnt[1];  // count during vsync differs per standard
        line_cnt <= 2'b00;
      end else if (hs_rise) begin
        line_cnt <= line_cnt + 2'd1;
      end
    end
  end

  assign vinfo = vinfo_t'{data_cnt: data_cnt, n64_480i: n64_480i, vmode: vmode};

  // a group is four nclk cycles, so ndsync stays high for three edges
  property p_group_spacing;
    @(negedge nclk) disable iff (!rst_n)
      !ndsync |=> ndsync [*3];
  endproperty

  a_group_spacing : assert property (p_group_spacing)
    else $error("ndsync low again before the pixel group ended");

endmodule

// ==== verilog/n64v_demux.sv ====
// bus demultiplexer: sync nibble history and registered rgb pixels
`timescale 1ns/100ps

module n64v_demux (
  input  logic                         nclk,
  input  logic                         rst_n,
  input  logic                         ndsync,
  input  logic [n64v_pkg::color_w-1:0] d,
  input  logic [1:0]                   data_cnt,   // slot from vinfo block
  output n64v_pkg::sync_t              sync_pre,
  output n64v_pkg::sync_t              sync_cur,
  output n64v_pkg::pixel_t             pixel,
  output logic                         pix_valid
);

  import n64v_pkg::*;

  logic [color_w-1:0] red_q;     // held until blue slot
  logic [color_w-1:0] green_q;
  logic               grp_seen;  // first ndsync low seen since reset

  // =========================================================================
  // sync history
  // =========================================================================

  // only updated in the sync slot, so vinfo sees the two previous
  // nibbles at the very edge where the next one arrives
  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      sync_pre <= '1;  // syncs idle high
      sync_cur <= '1;
    end else if (!ndsync) begin
      sync_pre <= sync_cur;
      sync_cur <= sync_t'(d[3:0]);
    end
  end

  // data_cnt free runs after reset, no pixel before a real group
  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n)
      grp_seen <= 1'b0;
    else if (!ndsync)
      grp_seen <= 1'b1;
  end

  // =========================================================================
  // colour slots
  // =========================================================================

  always_ff @(negedge nclk) begin
    if (ndsync && data_cnt == slot_red)
      red_q <= d;
    if (ndsync && data_cnt == slot_green)
      green_q <= d;
  end

  // blue completes the group, whole pixel goes out in one register stage
  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      pixel     <= '0;
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= 1'b0;  // single cycle strobe
      if (grp_seen && ndsync && data_cnt == slot_blue) begin
        pixel     <= pixel_t'{sync: sync_cur, r: red_q, g: green_q, b: d};
        pix_valid <= 1'b1;
      end
    end
  end

  // at most one pixel per group of four cycles
  property p_valid_single;
    @(negedge nclk) disable iff (!rst_n)
      pix_valid |=> !pix_valid;
  endproperty

  a_valid_single : assert property (p_valid_single)
    else $error("pix_valid high on two consecutive edges");

endmodule

// ==== verilog/n64v_line_meter.sv ====
// line meter that counts pixels per line and lines per frame and reports once per frame
`timescale 1ns/100ps

module n64v_line_meter #(
  parameter int hcnt_w = 12,  // pixel counter width
  parameter int vcnt_w = 10   // line counter width
) (
  input  logic                  nclk,
  input  logic                  rst_n,
  input  n64v_pkg::pixel_t      pixel,
  input  logic                  pix_valid,
  output n64v_pkg::line_stats_t stats,
  output logic                  stats_valid
);

  import n64v_pkg::*;

  sync_t             prev_sync;  // sync of the previous valid pixel
  logic [hcnt_w-1:0] hcnt;       // pixels in running line
  logic [hcnt_w-1:0] h_pix_q;    // pixels in last full line
  logic [vcnt_w-1:0] vcnt;       // lines in running frame

  logic              hs_fall, vs_fall;
  logic [hcnt_w-1:0] hcnt_inc, h_pix_nxt;
  logic [vcnt_w-1:0] vcnt_inc;

  assign hs_fall = prev_sync.nhsync & ~pixel.sync.nhsync;
  assign vs_fall = prev_sync.nvsync & ~pixel.sync.nvsync;

  // saturate instead of wrap on overlong lines/frames
  assign hcnt_inc  = (hcnt == {hcnt_w{1'b1}}) ? hcnt : hcnt + 1'b1;
  assign vcnt_inc  = (vcnt == {vcnt_w{1'b1}}) ? vcnt : vcnt + 1'b1;
  assign h_pix_nxt = hs_fall ? hcnt : h_pix_q;  // freshest line length

  // =========================================================================
  // counters that advance on valid pixels only
  // =========================================================================

  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      prev_sync <= '1;
      hcnt      <= '0;
      h_pix_q   <= '0;
      vcnt      <= '0;
    end else if (pix_valid) begin
      prev_sync <= pixel.sync;
      if (hs_fall) begin
        h_pix_q <= hcnt;
        hcnt    <= {{(hcnt_w-1){1'b0}}, 1'b1};  // this pixel starts the line
      end else begin
        hcnt <= hcnt_inc;
      end
      // a line starting on the vsync pixel belongs to the new frame
      if (vs_fall)
        vcnt <= hs_fall ? {{(vcnt_w-1){1'b0}}, 1'b1} : '0;
      else if (hs_fall)
        vcnt <= vcnt_inc;
    end
  end

  // =========================================================================
  // per frame record
  // =========================================================================

  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      stats       <= '0;
      stats_valid <= 1'b0;
    end else begin
      stats_valid <= pix_valid & vs_fall;
      if (pix_valid && vs_fall)
        stats <= line_stats_t'{h_pix:   h_pix_w'(h_pix_nxt),    // zero extend
                               v_lines: v_lines_w'(vcnt)};
    end
  end

  // the record goes out in the gap right after its vsync pixel
  property p_stats_after_pixel;
    @(negedge nclk) disable iff (!rst_n)
      stats_valid |-> $past(pix_valid) && !pix_valid;
  endproperty

  a_stats_after_pixel : assert property (p_stats_after_pixel)
    else $error("stats_valid outside the gap after a valid pixel");

endmodule

// ==== verilog/n64v_video_in.sv ====
// video input stage top: slot control, bus demux and line meter
`timescale 1ns/100ps

module n64v_video_in #(
  parameter int hcnt_w = 12,  // line meter pixel counter width
  parameter int vcnt_w = 10   // line meter line counter width
) (
  input  logic                         nclk,    // console pixel clock
  input  logic                         rst_n,
  input  logic                         ndsync,  // group strobe, low in sync slot
  input  logic [n64v_pkg::color_w-1:0] d,
  output n64v_pkg::pixel_t             pixel,
  output logic                         pix_valid,
  output n64v_pkg::vinfo_t             vinfo,
  output n64v_pkg::line_stats_t        stats,
  output logic                         stats_valid
);

  import n64v_pkg::*;

  sync_t sync_pre;  // demux -> vinfo, nibble history
  sync_t sync_cur;

  // =========================================================================
  // control
  // =========================================================================

  n64v_vinfo_ext u_vinfo (
    .nclk     (nclk),
    .rst_n    (rst_n),
    .ndsync   (ndsync),
    .sync_pre (sync_pre),
    .sync_cur (sync_cur),
    .vinfo    (vinfo)
  );

  // =========================================================================
  // datapath
  // =========================================================================

  n64v_demux u_demux (
    .nclk      (nclk),
    .rst_n     (rst_n),
    .ndsync    (ndsync),
    .d         (d),
    .data_cnt  (vinfo.data_cnt),  // slot select
    .sync_pre  (sync_pre),
    .sync_cur  (sync_cur),
    .pixel     (pixel),
    .pix_valid (pix_valid)
  );

  n64v_line_meter #(
    .hcnt_w (hcnt_w),
    .vcnt_w (vcnt_w)
  ) u_meter (
    .nclk        (nclk),
    .rst_n       (rst_n),
    .pixel       (pixel),
    .pix_valid   (pix_valid),
    .stats       (stats),
    .stats_valid (stats_valid)
  );

endmodule

// ==== verification/n64v_tb.sv ====
// video input stage testbench with console bus model, reference model and checks
`timescale 1ns/100ps

module n64v_tb;

  import n64v_pkg::*;

  // group count of all tests below
  localparam int total_groups = 40 + 4 + 9 * 16 * 8 + 3 * 16 * 6 + 4 * 20 * 9;
  localparam int timeout_ns   = total_groups * 40 + 2000;  // 40 ns per group plus margin

  logic        nclk;
  logic        rst_n;
  logic        ndsync;
  logic [6:0]  d;
  pixel_t      pixel;
  logic        pix_valid;
  vinfo_t      vinfo;
  line_stats_t stats;
  logic        stats_valid;

  int          err_cnt = 0;
  int          tests_run = 0;
  int          tests_bad = 0;
  int          pix_n = 0;   // pixels seen on the DUT output
  int          sv_n = 0;    // stats records seen
  logic [31:0] lcg_state = 32'd7;
  pixel_t      grp_q[$];    // groups sent and waiting for their sync slot

  n64v_video_in #(.hcnt_w(12), .vcnt_w(10)) dut0 (
    .nclk(nclk), .rst_n(rst_n), .ndsync(ndsync), .d(d),
    .pixel(pixel), .pix_valid(pix_valid), .vinfo(vinfo),
    .stats(stats), .stats_valid(stats_valid)
  );

  always #5 nclk = ~nclk;

  // =========================================================================
  // reference model of the console bus rules
  // =========================================================================

  logic [1:0]  m_cnt;              // data slot
  logic        m_seen;             // a group has started
  pixel_t      m_grp, m_pixel;
  logic        m_valid;
  sync_t       m_pre, m_cur;
  logic        m_fid, m_480i, m_vmode;
  logic [1:0]  m_lc;
  sync_t       m_prev;             // meter sync of the last valid pixel
  logic [11:0] m_hcnt, m_hpix;
  logic [9:0]  m_lines;
  line_stats_t m_stats;
  logic        m_sv;

  always @(negedge nclk or negedge rst_n) begin : ref_model
    logic vsf, vsr, hsf, hsr, mhf, mvf;
    if (!rst_n) begin
      m_cnt   <= 0;
      m_seen  <= 0;
      m_grp   <= '0;
      m_pixel <= '0;
      m_valid <= 0;
      m_pre   <= '1;
      m_cur   <= '1;
      m_fid   <= 0;
      m_480i  <= 1;
      m_vmode <= 0;
      m_lc    <= 0;
      m_prev  <= '1;
      m_hcnt  <= 0;
      m_hpix  <= 0;
      m_lines <= 0;
      m_stats <= '0;
      m_sv    <= 0;
    end else begin
      m_cnt <= ndsync ? m_cnt + 2'd1 : 2'd1;
      if (!ndsync) begin
        m_seen <= 1;
        if (grp_q.size() > 0)
          m_grp <= grp_q.pop_front();
        m_pre <= m_cur;
        m_cur <= sync_t'(d[3:0]);
        // mode rules see the two nibbles before this one
        vsf = m_pre.nvsync && !m_cur.nvsync;
        vsr = !m_pre.nvsync && m_cur.nvsync;
        hsf = m_pre.nhsync && !m_cur.nhsync;
        hsr = !m_pre.nhsync && m_cur.nhsync;
        if (vsf) begin
          m_480i <= (hsf != m_fid);  // frame id changed
          m_fid  <= hsf;             // odd when hsync falls too
        end
        if (vsr) begin
          m_vmode <= !m_lc[1];
          m_lc    <= 0;
        end else if (hsr) begin
          m_lc <= m_lc + 2'd1;
        end
      end
      // pixel complete at the blue slot
      m_valid <= m_seen && ndsync && m_cnt == 2'd3;
      if (m_seen && ndsync && m_cnt == 2'd3)
        m_pixel <= m_grp;
      // line meter on the model's own pixel stream
      mhf = m_valid && m_prev.nhsync && !m_pixel.sync.nhsync;
      mvf = m_valid && m_prev.nvsync && !m_pixel.sync.nvsync;
      m_sv <= mvf;
      if (m_valid) begin
        m_prev <= m_pixel.sync;
        if (mhf) begin
          m_hpix  <= m_hcnt;
          m_hcnt  <= 12'd1;          // this pixel opens the line
          m_lines <= m_lines + 10'd1;
        end else begin
          m_hcnt <= m_hcnt + 12'd1;
        end
        if (mvf) begin
          m_stats.h_pix   <= mhf ? m_hcnt : m_hpix;
          m_stats.v_lines <= m_lines;
          m_lines         <= mhf ? 10'd1 : 10'd0;  // new line counts for the new frame
        end
      end
    end
  end

  always @(negedge nclk) begin
    if (rst_n && pix_valid)
      pix_n++;
    if (rst_n && stats_valid)
      sv_n++;
  end

  // =========================================================================
  // checks against the model
  // =========================================================================

  function automatic void log_mismatch(input string name, input logic [31:0] exp,
                                       input logic [31:0] got);
    $display("Fail %s exp %h got %h", name, exp, got);
    err_cnt++;
  endfunction

  a_pix_valid : assert property (@(negedge nclk) disable iff (!rst_n) pix_valid == m_valid)
    else log_mismatch("pix_valid", m_valid, pix_valid);
  a_pixel : assert property (@(negedge nclk) disable iff (!rst_n)
      pix_valid |-> pixel == m_pixel)
    else log_mismatch("pixel", m_pixel, pixel);
  a_data_cnt : assert property (@(negedge nclk) disable iff (!rst_n) vinfo.data_cnt == m_cnt)
    else log_mismatch("data_cnt", m_cnt, vinfo.data_cnt);
  a_480i : assert property (@(negedge nclk) disable iff (!rst_n) vinfo.n64_480i == m_480i)
    else log_mismatch("n64_480i", m_480i, vinfo.n64_480i);
  a_vmode : assert property (@(negedge nclk) disable iff (!rst_n) vinfo.vmode == m_vmode)
    else log_mismatch("vmode", m_vmode, vinfo.vmode);
  a_stats_valid : assert property (@(negedge nclk) disable iff (!rst_n) stats_valid == m_sv)
    else log_mismatch("stats_valid", m_sv, stats_valid);
  a_stats : assert property (@(negedge nclk) disable iff (!rst_n)
      stats_valid |-> stats == m_stats)
    else log_mismatch("stats", m_stats, stats);

  // =========================================================================
  // stimulus helpers
  // =========================================================================

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [6:0] rand_color();
    lcg_state = lcg_next(lcg_state);
    return lcg_state[22:16];
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp == got)
      else log_mismatch(name, exp, got);
  endtask

  // one group of sync slot then r, g, b with an optional slot counter check
  task automatic send_group(input sync_t s, input bit chk_cnt);
    pixel_t p;
    p.sync = s;
    p.r = rand_color();
    p.g = rand_color();
    p.b = rand_color();
    grp_q.push_back(p);
    @(posedge nclk);
    ndsync = 1'b0;
    d      = {3'b000, s};
    for (int i = 1; i <= 3; i++) begin
      @(posedge nclk);
      if (chk_cnt)
        expect_eq("data_cnt", i, vinfo.data_cnt);
      ndsync = 1'b1;
      d      = (i == 1) ? p.r : (i == 2) ? p.g : p.b;
    end
    if (chk_cnt) begin
      @(negedge nclk);
      #1 expect_eq("data_cnt", 0, vinfo.data_cnt);  // wrapped after blue
    end
  endtask

  // hsync low for two pixels per line, vsync low for three lines;
  // odd frames drop vsync together with hsync, even ones mid line
  task automatic send_frame(input int pix, input int lines, input bit odd);
    int    vpos;
    int    pos;
    sync_t s;
    vpos = odd ? 0 : pix / 2;
    for (int l = 0; l < lines; l++) begin
      for (int p = 0; p < pix; p++) begin
        pos      = l * pix + p;
        s.nhsync = (p >= 2);
        s.nvsync = !(pos >= vpos && pos < 3 * pix + vpos);
        s.nclamp = 1'b1;
        s.ncsync = s.nhsync & s.nvsync;
        send_group(s, 1'b0);
      end
    end
  endtask

  task automatic end_test(input string name, input int err_start);
    tests_run++;
    if (err_cnt != err_start)
      tests_bad++;
    $display("test %0d %s: %s", tests_run, name, (err_cnt == err_start) ? "ok" : "failed");
  endtask

  // =========================================================================
  // tests
  // =========================================================================

  initial begin : watchdog
    #(timeout_ns);
    $display("timeout: the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int e, n;
    nclk   = 1'b0;
    rst_n  = 1'b0;
    ndsync = 1'b1;
    d      = '0;

    // reset values
    e = err_cnt;
    repeat (4) @(posedge nclk);
    expect_eq("vinfo", vinfo_t'{data_cnt: 2'd0, n64_480i: 1'b1, vmode: 1'b0}, vinfo);
    rst_n = 1'b1;
    repeat (3) @(posedge nclk);
    expect_eq("pix_valid", 0, pix_valid);
    expect_eq("stats_valid", 0, stats_valid);
    expect_eq("n64_480i", 1, vinfo.n64_480i);
    expect_eq("vmode", 0, vinfo.vmode);
    end_test("reset", e);

    // random colours give one pixel per group
    e = err_cnt;
    n = pix_n;
    for (int i = 0; i < 40; i++)
      send_group(sync_t'({2'b11, 1'b1, rand_color() > 7'd63}), 1'b0);
    expect_eq("pixel count", 39, pix_n - n);  // last one still in flight
    end_test("pixels", e);

    // slot counter over a few groups
    e = err_cnt;
    repeat (4) send_group(sync_t'(4'hf), 1'b1);
    end_test("slot counter", e);

    // interlace detection
    e = err_cnt;
    send_frame(16, 8, 1'b1);
    send_frame(16, 8, 1'b0);
    send_frame(16, 8, 1'b1);
    expect_eq("n64_480i", 1, vinfo.n64_480i);
    repeat (3) send_frame(16, 8, 1'b0);
    expect_eq("n64_480i", 0, vinfo.n64_480i);
    end_test("interlace", e);

    // pal/ntsc from the line count
    e = err_cnt;
    repeat (3) send_frame(16, 8, 1'b0);
    expect_eq("vmode", 1, vinfo.vmode);      // 8 lines leave counter bit 1 at 0
    repeat (3) send_frame(16, 6, 1'b0);
    expect_eq("vmode", 0, vinfo.vmode);      // 6 lines leave counter bit 1 at 1
    end_test("pal/ntsc", e);

    // line meter
    e = err_cnt;
    n = sv_n;
    repeat (4) send_frame(20, 9, 1'b1);
    expect_eq("stats_valid count", 4, sv_n - n);
    expect_eq("h_pix", 20, stats.h_pix);
    expect_eq("v_lines", 9, stats.v_lines);
    end_test("line meter", e);

    // let the last pixel leave before the bus goes idle
    repeat (2) @(negedge nclk);
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_bad, err_cnt);
    if (err_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== files.f ====
common/n64v_pkg.sv
vinfo/n64v_vinfo_ext.sv
verilog/n64v_demux.sv
verilog/n64v_line_meter.sv
verilog/n64v_video_in.sv
verification/n64v_tb.sv

// ==== Makefile ====
# Verilator build and run of the video input stage testbench

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module n64v_tb -o vtb
	./obj_dir/vtb | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
